// File: hw/trdb_consts.svh
// widths shared by the trace packet emitter
// keep_bits is assumed to stay within 0..XLEN, the address compression relies on it
`ifndef TRDB_CONSTS_SVH
`define TRDB_CONSTS_SVH

// instruction address width
`define TRDB_XLEN 64

// exception cause width
`define TRDB_CAUSE_LEN 5

// privilege level width
`define TRDB_PRIV_LEN 2

// return depth field, format 2 only
`define TRDB_IRDEPTH_LEN 4

// number of address bits to keep, 0..64
`define TRDB_KEEP_LEN 7

// payload word, wide enough for the largest trap packet
`define TRDB_PAYLOAD_LEN 160

// payload length in bytes
`define TRDB_PLEN_LEN 5

`endif

// File: hw/trdb_format_pkg.sv
// encodings of the packet formats and of the encoder option fields
// only start, trap, support and address-only are emitted by this design
`default_nettype none

package trdb_format_pkg;

    // packet format, bits 1:0 of every payload
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'h0,
        F_DIFF_DELTA = 2'h1,
        F_ADDR_ONLY  = 2'h2,
        F_SYNC       = 2'h3
    } trdb_format_e;

    // subformat of a sync packet, bits 3:2
    typedef enum logic [1:0] {
        SF_START   = 2'h0,
        SF_TRAP    = 2'h1,
        SF_CONTEXT = 2'h2,
        SF_SUPPORT = 2'h3
    } trdb_sync_sub_e;

    // qualification status reported in the support packet
    typedef enum logic [1:0] {
        NO_CHANGE  = 2'h0,
        ENDED_REP  = 2'h1,
        TRACE_LOST = 2'h2,
        ENDED_NTR  = 2'h3
    } trdb_qual_status_e;

    // instruction trace options
    typedef enum logic [2:0] {
        DELTA_ADDRESS      = 3'h0,
        FULL_ADDRESS       = 3'h1,
        IMPLICIT_EXCEPTION = 3'h2,
        SIJUMP             = 3'h3,
        IMPLICIT_RETURN    = 3'h4,
        BRANCH_PREDICTION  = 3'h5,
        JUMP_TARGET_CACHE  = 3'h6
    } trdb_ioptions_e;

endpackage

`default_nettype wire

// File: hw/trdb_packet_pkg.sv
// request, trap and address types plus the two views of a payload word
// the request carries everything for one packet, sampled with valid
`default_nettype none

`include "trdb_consts.svh"

package trdb_packet_pkg;

    import trdb_format_pkg::*;

    // cause, tval and interrupt flag seen in one cycle
    typedef struct packed {
        logic [`TRDB_CAUSE_LEN-1:0] cause;
        logic [`TRDB_XLEN-1:0]      tval;
        logic                       interrupt;
    } trdb_trap_t;

    // one trace request from the priority stage
    typedef struct packed {
        trdb_format_e               format;
        trdb_sync_sub_e             subformat;
        logic                       branch;
        logic                       branch_taken;
        logic [`TRDB_PRIV_LEN-1:0]  priv;
        // this cycle instruction address
        logic [`TRDB_XLEN-1:0]      iaddr;
        // last cycle was an uninferable discontinuity
        logic                       lc_updiscon;
        // picks tc_trap over lc_trap in a trap packet
        logic                       lc_tc_mux;
        trdb_trap_t                 lc_trap;
        trdb_trap_t                 tc_trap;
        // trap handler address valid
        logic                       thaddr;
        // handler base, word aligned
        logic [`TRDB_XLEN-1:2]      tvec;
        logic [`TRDB_XLEN-1:0]      lc_epc;
        // support packet fields
        logic                       ienable;
        logic                       encoder_mode;
        trdb_qual_status_e          qual_status;
        trdb_ioptions_e             ioptions;
    } trdb_request_t;

    // address picked for the current format and its compressed size
    typedef struct packed {
        logic [`TRDB_XLEN-1:0] addr;
        // bytes kept, 0..8
        logic [3:0]            bytes;
    } trdb_addr_info_t;

    // format 3 view, format and subformat at the bottom
    typedef struct packed {
        logic [`TRDB_PAYLOAD_LEN-5:0] body;
        trdb_sync_sub_e               subformat;
        trdb_format_e                 format;
    } trdb_sync_view_t;

    // format 2 view, no subformat
    typedef struct packed {
        logic [`TRDB_PAYLOAD_LEN-3:0] body;
        trdb_format_e                 format;
    } trdb_addr_view_t;

    // format lands in bits 1:0 in both views
    typedef union packed {
        trdb_sync_view_t sync_view;
        trdb_addr_view_t addr_view;
    } trdb_payload_u;

endpackage

`default_nettype wire

// File: hw/trdb_addr_tracker.sv
// latest emitted address, trap and differential address, byte count
// addr_info and addr_to_compress are combinational from the current request
`timescale 1ns/1ps
`default_nettype none

`include "trdb_consts.svh"

module trdb_addr_tracker (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             valid_i,
    input  trdb_packet_pkg::trdb_request_t   req_i,
    input  logic [`TRDB_KEEP_LEN-1:0]        keep_bits_i,
    input  logic                             latest_update_i,
    output trdb_packet_pkg::trdb_addr_info_t addr_info_o,
    output logic [`TRDB_XLEN-1:0]            addr_to_compress_o
);
    import trdb_format_pkg::*;

    logic [`TRDB_XLEN-1:0] latest_addr_q;
    logic [`TRDB_XLEN-1:0] trap_addr;
    logic [`TRDB_XLEN-1:0] diff_addr;
    logic                  is_start;
    logic                  is_trap;
    logic                  is_addr_only;
    logic                  full_addr;

    // format decode
    assign is_start     = (req_i.format == F_SYNC) && (req_i.subformat == SF_START);
    assign is_trap      = (req_i.format == F_SYNC) && (req_i.subformat == SF_TRAP);
    assign is_addr_only = (req_i.format == F_ADDR_ONLY);
    assign full_addr    = (req_i.ioptions == FULL_ADDRESS);

    // handler address when known, else the faulting pc
    assign trap_addr = req_i.thaddr ? {req_i.tvec, 2'b00} : req_i.lc_epc;

    // delta against the last address sent out
    assign diff_addr = req_i.iaddr - latest_addr_q;

    // ceil(keep_bits / 8)
    assign addr_info_o.bytes = keep_bits_i[`TRDB_KEEP_LEN-1:3] + {3'b000, |keep_bits_i[2:0]};

    // address that goes into the packet
    always_comb begin
        addr_info_o.addr = '0;
        if (is_trap) begin
            addr_info_o.addr = trap_addr;
        end else if (is_start) begin
            addr_info_o.addr = req_i.iaddr;
        end else if (is_addr_only) begin
            addr_info_o.addr = diff_addr;
        end
    end

    // feedback to the priority stage, only during a request
    always_comb begin
        addr_to_compress_o = '0;
        if (valid_i) begin
            if (is_trap && full_addr) begin
                addr_to_compress_o = trap_addr;
            end else if (is_start) begin
                addr_to_compress_o = req_i.iaddr;
            end else if (is_addr_only && !full_addr) begin
                addr_to_compress_o = diff_addr;
            end
        end
    end

    // last address emitted in a packet
    // next request already sees the new value
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            latest_addr_q <= '0;
        end else if (latest_update_i) begin
            latest_addr_q <= req_i.iaddr;
        end
    end

endmodule

`default_nettype wire

// File: hw/trdb_payload_packer.sv
// packs start, trap, support and address-only packets, output registered
// other formats give a zero length packet with only the format bits set
`timescale 1ns/1ps
`default_nettype none

`include "trdb_consts.svh"

module trdb_payload_packer (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             valid_i,
    input  trdb_packet_pkg::trdb_request_t   req_i,
    input  trdb_packet_pkg::trdb_addr_info_t addr_info_i,
    output logic                             latest_update_o,
    output logic                             packet_valid_o,
    output trdb_packet_pkg::trdb_payload_u   packet_payload_o,
    output logic [`TRDB_PLEN_LEN-1:0]        payload_length_o
);
    import trdb_format_pkg::*;
    import trdb_packet_pkg::*;

    localparam int unsigned SyncBodyLen = `TRDB_PAYLOAD_LEN - 4;
    localparam int unsigned AddrBodyLen = `TRDB_PAYLOAD_LEN - 2;

    logic                             branch;
    trdb_trap_t                       trap_sel;
    logic [7:0]                       addr_bits;
    logic [`TRDB_XLEN-1:0]            addr_mask;
    logic [`TRDB_XLEN-1:0]            addr_field;
    logic                             notify;
    logic                             updiscon;
    logic                             irreport;
    logic [`TRDB_IRDEPTH_LEN-1:0]     irdepth;
    logic [`TRDB_IRDEPTH_LEN+2:0]     side_field;
    logic [7:0]                       used_bits;
    trdb_payload_u                    payload_d;
    logic [`TRDB_PLEN_LEN-1:0]        length_d;

    // bits rounded up to whole bytes
    function automatic logic [`TRDB_PLEN_LEN-1:0] ceil_bytes(input logic [7:0] bits);
        return bits[7:3] + {4'b0000, |bits[2:0]};
    endfunction

    // 0 means a taken branch
    assign branch = ~(req_i.branch && req_i.branch_taken);

    // this cycle or last cycle trap info
    assign trap_sel = req_i.lc_tc_mux ? req_i.tc_trap : req_i.lc_trap;

    // address compression, keep the low n bytes
    // shift of 64 gives zero so n = 8 keeps the full word
    assign addr_bits  = {1'b0, addr_info_i.bytes, 3'b000};
    assign addr_mask  = ~({`TRDB_XLEN{1'b1}} << addr_bits);
    assign addr_field = addr_info_i.addr & addr_mask;

    // format 2 sideband, no trigger unit and no implicit return
    assign notify     = req_i.iaddr[`TRDB_XLEN-1];
    assign updiscon   = notify ^ req_i.lc_updiscon;
    assign irreport   = updiscon;
    assign irdepth    = {`TRDB_IRDEPTH_LEN{updiscon}};
    assign side_field = {irdepth, irreport, updiscon, notify};

    always_comb begin
        payload_d       = '0;
        used_bits       = '0;
        latest_update_o = 1'b0;
        // format bits overlap in both views
        payload_d.addr_view.format = req_i.format;
        case (req_i.format)
            F_SYNC: begin
                payload_d.sync_view.subformat = req_i.subformat;
                case (req_i.subformat)
                    SF_START: begin
                        // branch, priv, address
                        payload_d.sync_view.body =
                            SyncBodyLen'({req_i.priv, branch}) |
                            (SyncBodyLen'(addr_field) << 3);
                        used_bits       = 8'd7 + addr_bits;
                        latest_update_o = valid_i;
                    end
                    SF_TRAP: begin
                        // tval sits right above the compressed address
                        payload_d.sync_view.body =
                            SyncBodyLen'({req_i.thaddr, trap_sel.interrupt,
                                          trap_sel.cause, req_i.priv, branch}) |
                            (SyncBodyLen'(addr_field) << 10) |
                            (SyncBodyLen'(trap_sel.tval) << (8'd10 + addr_bits));
                        used_bits       = 8'd78 + addr_bits;
                        latest_update_o = valid_i;
                    end
                    SF_SUPPORT: begin
                        payload_d.sync_view.body =
                            SyncBodyLen'({req_i.ioptions, req_i.qual_status,
                                          req_i.encoder_mode, req_i.ienable});
                        used_bits = 8'd11;
                    end
                    default: begin
                        // context not supported, header only
                        used_bits = '0;
                    end
                endcase
            end
            F_ADDR_ONLY: begin
                // differential address then sideband
                payload_d.addr_view.body =
                    AddrBodyLen'(addr_field) |
                    (AddrBodyLen'(side_field) << addr_bits);
                used_bits       = 8'd9 + addr_bits;
                latest_update_o = valid_i;
            end
            default: begin
                // formats 0 and 1 dropped
                used_bits = '0;
            end
        endcase
    end

    assign length_d = ceil_bytes(used_bits);

    // one cycle latency, payload held between packets
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o   <= 1'b0;
            packet_payload_o <= '0;
            payload_length_o <= '0;
        end else begin
            packet_valid_o <= valid_i;
            if (valid_i) begin
                packet_payload_o <= payload_d;
                payload_length_o <= length_d;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/trdb_packet_emitter.sv
// trace packet emitter, one packet per valid strobe one cycle later
// no back-pressure, a packet is valid for a single cycle
`timescale 1ns/1ps
`default_nettype none

`include "trdb_consts.svh"

module trdb_packet_emitter (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           valid_i,
    input  trdb_packet_pkg::trdb_request_t req_i,
    input  logic [`TRDB_KEEP_LEN-1:0]      keep_bits_i,
    output logic                           packet_valid_o,
    output trdb_packet_pkg::trdb_payload_u packet_payload_o,
    output logic [`TRDB_PLEN_LEN-1:0]      payload_length_o,
    output logic [`TRDB_XLEN-1:0]          addr_to_compress_o
);
    import trdb_packet_pkg::*;

    // tracker to packer, same cycle
    trdb_addr_info_t addr_info;
    // packer back to tracker, loads the latest address
    logic            latest_update;

    // address side
    trdb_addr_tracker i_addr_tracker (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .valid_i            (valid_i),
        .req_i              (req_i),
        .keep_bits_i        (keep_bits_i),
        .latest_update_i    (latest_update),
        .addr_info_o        (addr_info),
        .addr_to_compress_o (addr_to_compress_o)
    );

    // payload assembly and output register
    trdb_payload_packer i_payload_packer (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .valid_i          (valid_i),
        .req_i            (req_i),
        .addr_info_i      (addr_info),
        .latest_update_o  (latest_update),
        .packet_valid_o   (packet_valid_o),
        .packet_payload_o (packet_payload_o),
        .payload_length_o (payload_length_o)
    );

endmodule

`default_nettype wire

// File: testbench/trdb_packet_emitter_assertions.sv
// protocol checks on the emitter outputs bound into the top level
// assumes valid_i is low while reset is asserted
`timescale 1ns/1ps
`default_nettype none

module trdb_packet_emitter_assertions (
    input wire logic                           clk_i,
    input wire logic                           rst_ni,
    input wire logic                           valid_i,
    input wire trdb_packet_pkg::trdb_request_t req_i,
    input wire logic                           packet_valid_o,
    input wire trdb_packet_pkg::trdb_payload_u packet_payload_o
);

    // number of assertion failures so far
    int fail_count = 0;

    // no packet while in reset
    property quiet_in_reset;
        @(posedge clk_i) !rst_ni |-> !packet_valid_o;
    endproperty

    // one packet per strobe one cycle later
    property valid_follows_request;
        @(posedge clk_i) disable iff (!rst_ni)
            packet_valid_o == $past(valid_i);
    endproperty

    // format bits match the request that made the packet
    property format_in_low_bits;
        @(posedge clk_i) disable iff (!rst_ni)
            packet_valid_o |-> packet_payload_o.addr_view.format == $past(req_i.format);
    endproperty

    assert property (quiet_in_reset)
        else begin
            $error("packet_valid_o high during reset");
            fail_count++;
        end
    assert property (valid_follows_request)
        else begin
            $error("packet_valid_o does not follow valid_i by one cycle");
            fail_count++;
        end
    assert property (format_in_low_bits)
        else begin
            $error("payload format bits differ from the request format");
            fail_count++;
        end

endmodule

bind trdb_packet_emitter trdb_packet_emitter_assertions u_assertions (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .valid_i          (valid_i),
    .req_i            (req_i),
    .packet_valid_o   (packet_valid_o),
    .packet_payload_o (packet_payload_o)
);

`default_nettype wire

// File: testbench/trdb_packet_emitter_tb.sv
// file driven testbench for the packet emitter
// stimulus path is relative to the project root
// each stimulus record is a request line followed by an expected line
`timescale 1ns/1ps
`default_nettype none

`include "trdb_consts.svh"

module trdb_packet_emitter_tb;
    import trdb_format_pkg::*;
    import trdb_packet_pkg::*;

    localparam int WaitLimit = 8;

    logic                       clk_i;
    logic                       rst_ni;
    logic                       valid_i;
    trdb_request_t              req_i;
    logic [`TRDB_KEEP_LEN-1:0]  keep_bits_i;
    logic                       packet_valid_o;
    trdb_payload_u              packet_payload_o;
    logic [`TRDB_PLEN_LEN-1:0]  payload_length_o;
    logic [`TRDB_XLEN-1:0]      addr_to_compress_o;

    int mismatch_count;
    int other_count;
    int assert_count;
    int packet_count;

    trdb_packet_emitter UUT (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .valid_i            (valid_i),
        .req_i              (req_i),
        .keep_bits_i        (keep_bits_i),
        .packet_valid_o     (packet_valid_o),
        .packet_payload_o   (packet_payload_o),
        .payload_length_o   (payload_length_o),
        .addr_to_compress_o (addr_to_compress_o)
    );

    // 20 ns clock
    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // next line that is not a comment or blank
    // returns an empty string at end of file
    task automatic next_data_line(input int fd, output string line);
        int    rc;
        string raw;
        line = "";
        while (!$feof(fd)) begin
            raw = "";
            rc = $fgets(raw, fd);
            if (rc > 0 && raw.len() > 1 && raw.getc(0) != "#") begin
                line = raw;
                break;
            end
        end
    endtask

    initial begin
        int                         fd;
        int                         rc;
        int                         cnt;
        string                      line;
        string                      name;
        int                         gap;
        logic [1:0]                 fmt;
        logic [1:0]                 sub;
        logic                       br;
        logic                       tk;
        logic [`TRDB_PRIV_LEN-1:0]  priv;
        logic [`TRDB_XLEN-1:0]      iaddr;
        logic                       lcupd;
        logic                       mux;
        logic                       thaddr;
        logic [`TRDB_XLEN-1:0]      tvec;
        logic [`TRDB_XLEN-1:0]      epc;
        logic [`TRDB_CAUSE_LEN-1:0] lc_cause;
        logic [`TRDB_XLEN-1:0]      lc_tval;
        logic                       lc_int;
        logic [`TRDB_CAUSE_LEN-1:0] tc_cause;
        logic [`TRDB_XLEN-1:0]      tc_tval;
        logic                       tc_int;
        logic                       ien;
        logic                       emode;
        logic [1:0]                 qual;
        logic [2:0]                 iopt;
        logic [`TRDB_KEEP_LEN-1:0]  keep;
        logic [`TRDB_PAYLOAD_LEN-1:0] exp_payload;
        logic [`TRDB_PLEN_LEN-1:0]  exp_len;
        logic [`TRDB_XLEN-1:0]      exp_cmp;

        mismatch_count = 0;
        other_count    = 0;
        assert_count   = 0;
        packet_count   = 0;
        rst_ni         = 1'b0;
        valid_i        = 1'b0;
        req_i          = '0;
        keep_bits_i    = '0;

        // reset held for 16 cycles and released just after an edge
        repeat (16) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        fd = $fopen("testbench/trdb_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            other_count++;
        end else begin
            next_data_line(fd, line);
            while (line.len() > 0) begin
                rc = $sscanf(line,
                    "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, gap, fmt, sub, br, tk, priv, iaddr, lcupd, mux, thaddr, tvec, epc,
                    lc_cause, lc_tval, lc_int, tc_cause, tc_tval, tc_int,
                    ien, emode, qual, iopt, keep);
                next_data_line(fd, line);
                if (rc != 24 ||
                    $sscanf(line, "%h %h %h", exp_payload, exp_len, exp_cmp) != 3) begin
                    $display("stimulus record %s is malformed", name);
                    other_count++;
                    break;
                end

                // idle cycles before the request
                // a zero gap gives back to back requests
                if (gap > 0) begin
                    valid_i = 1'b0;
                    repeat (gap) @(posedge clk_i);
                    #2;
                end

                req_i                  = '0;
                req_i.format           = trdb_format_e'(fmt);
                req_i.subformat        = trdb_sync_sub_e'(sub);
                req_i.branch           = br;
                req_i.branch_taken     = tk;
                req_i.priv             = priv;
                req_i.iaddr            = iaddr;
                req_i.lc_updiscon      = lcupd;
                req_i.lc_tc_mux        = mux;
                req_i.thaddr           = thaddr;
                // handler base drops its two low bits
                req_i.tvec             = tvec[`TRDB_XLEN-1:2];
                req_i.lc_epc           = epc;
                req_i.lc_trap.cause    = lc_cause;
                req_i.lc_trap.tval     = lc_tval;
                req_i.lc_trap.interrupt = lc_int;
                req_i.tc_trap.cause    = tc_cause;
                req_i.tc_trap.tval     = tc_tval;
                req_i.tc_trap.interrupt = tc_int;
                req_i.ienable          = ien;
                req_i.encoder_mode     = emode;
                req_i.qual_status      = trdb_qual_status_e'(qual);
                req_i.ioptions         = trdb_ioptions_e'(iopt);
                keep_bits_i            = keep;
                valid_i                = 1'b1;

                // compression feedback is combinational in the request cycle
                #1;
                if (addr_to_compress_o !== exp_cmp) begin
                    $display("Mismatch %s addr_to_compress expected %h actual %h",
                             name, exp_cmp, addr_to_compress_o);
                    mismatch_count++;
                end

                // packet expected on the next edge
                @(posedge clk_i);
                #1;
                cnt = 0;
                while (!packet_valid_o && cnt < WaitLimit) begin
                    @(posedge clk_i);
                    #1;
                    cnt++;
                end
                if (!packet_valid_o) begin
                    $display("no packet came out for request %s", name);
                    other_count++;
                    break;
                end
                packet_count++;
                if (packet_payload_o !== exp_payload) begin
                    $display("Mismatch %s payload expected %h actual %h",
                             name, exp_payload, packet_payload_o);
                    mismatch_count++;
                end
                if (payload_length_o !== exp_len) begin
                    $display("Mismatch %s length expected %0d actual %0d",
                             name, exp_len, payload_length_o);
                    mismatch_count++;
                end
                // back at edge plus 2 ns for the next drive
                #1;
                next_data_line(fd, line);
            end
            $fclose(fd);
        end

        valid_i = 1'b0;
        repeat (3) @(posedge clk_i);
        if (packet_count == 0 && other_count == 0) begin
            $display("stimulus file held no requests");
            other_count++;
        end
        assert_count = UUT.u_assertions.fail_count;
        $display("packets checked %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 packet_count, mismatch_count, other_count, assert_count);
        if (mismatch_count == 0 && other_count == 0 && assert_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/trdb_stimulus.txt
# req: name gap fmt sub br tk priv iaddr lcupd mux thaddr tvec epc lc_cause lc_tval lc_int
#      tc_cause tc_tval tc_int ien emode qual iopt keep   (hex, gap in idle cycles)
# exp: payload length addr_to_compress   (hex, on the line after its request)
addr_first_after_reset 2 2 0 0 0 0 1234 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10
48d2 4 1234
start_keep7 0 3 0 0 0 3 80001234 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 7
1a73 2 80001234
start_keep10 0 3 0 1 1 1 123456789abcdef0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 a
6f7823 3 123456789abcdef0
start_keep25 0 3 0 1 0 0 ffff000011112222 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 19
888911113 5 ffff000011112222
start_keep64 0 3 0 0 0 2 123456789abcdef 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 40
91a2b3c4d5e6f7d3 9 123456789abcdef
addr_delta 0 2 0 0 0 0 123456789abd000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10
846 4 211
addr_updiscon 1 2 0 0 0 0 123456789abd010 1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8
1f842 3 0
addr_notify 0 2 0 0 0 0 8000000000000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 c
1fcbfc2 4 7edcba9876542ff0
trap_handler 3 3 1 0 0 3 2000 0 0 1 1f00 4000 5 deadbeef 0 1a 1111 1 0 0 0 1 10
37ab6fbbc7c022f7 c 1f00
trap_epc_tc 0 3 1 1 1 0 3000 0 1 0 1f00 4abc 5 deadbeef 0 1a 1111 1 0 0 0 0 8
4446f1d07 b 0
support 0 3 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 2 5 0
59f 2 0

// File: trdb_packet_emitter.f
+incdir+hw
hw/trdb_format_pkg.sv
hw/trdb_packet_pkg.sv
hw/trdb_addr_tracker.sv
hw/trdb_payload_packer.sv
hw/trdb_packet_emitter.sv
testbench/trdb_packet_emitter_assertions.sv
testbench/trdb_packet_emitter_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = trdb_packet_emitter_tb
FILELIST  = trdb_packet_emitter.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
